/* hdl/uart_params.svh */
// UART defines: frame and register widths, FIFO size, reset divisor, register map
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// Data bits per frame and host register word
`define UART_DATA_W      8
`define UART_WORD_W      16

// Transmit FIFO, depth is a power of two
`define UART_FIFO_DEPTH  8
`define UART_FIFO_AW     3

// Baud divisor, one bit lasts divisor + 1 clocks
`define UART_DIV_W       12
`define UART_RESET_DIV   12'd15

// Register map
`define UART_ADDR_W      2
`define UART_ADDR_CTRL   2'd0
`define UART_ADDR_DATA   2'd1
`define UART_ADDR_STATUS 2'd2

`endif

/* hdl/uart_line_pkg.sv */
// Serial line types: parity mode and latched frame settings
`include "uart_params.svh"

package uart_line_pkg;

    // ----------------------------------------------------------
    // Parity selection
    // ----------------------------------------------------------

    // Encoding 2'd3 is unused and behaves like even parity
    typedef enum logic [1:0]
    {
        PAR_NONE = 2'd0,
        PAR_EVEN = 2'd1,
        PAR_ODD  = 2'd2
    } parity_mode_e;

    // ----------------------------------------------------------
    // Frame settings
    // ----------------------------------------------------------

    // Divisor in the upper bits, parity mode in the lowest two
    typedef struct packed
    {
        logic [`UART_DIV_W-1:0] divisor;
        logic                   stop_two;
        parity_mode_e           parity;
    } line_cfg_t;

endpackage

/* hdl/uart_reg_pkg.sv */
// Register map types: union decoding one register word as control, data or status
`include "uart_params.svh"

package uart_reg_pkg;

    // ----------------------------------------------------------
    // One host word, three layouts
    // ----------------------------------------------------------

    typedef union packed
    {
        // CTRL, divisor in the low 12 bits
        struct packed
        {
            logic [`UART_WORD_W-`UART_DIV_W-4:0] rsvd;
            uart_line_pkg::parity_mode_e         parity;
            logic                                stop_two;
            logic [`UART_DIV_W-1:0]              divisor;
        } ctrl;

        // DATA, byte in the low half
        struct packed
        {
            logic [`UART_WORD_W-`UART_DATA_W-1:0] rsvd;
            logic [`UART_DATA_W-1:0]              value;
        } data;

        // STATUS, FIFO level in the low nibble
        struct packed
        {
            logic [`UART_WORD_W-`UART_FIFO_AW-6:0] rsvd;
            logic                                  overflow;
            logic                                  busy;
            logic                                  full;
            logic                                  empty;
            logic [`UART_FIFO_AW:0]                level;
        } status;
    } reg_word_u;

endpackage

/* hdl/uart_regs.sv */
// Host register block: write decode, line settings, byte push, status word
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_regs
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr_en,
    input  logic                      rd_en,
    input  logic [`UART_ADDR_W-1:0]   addr,
    input  uart_reg_pkg::reg_word_u   wdata,
    output uart_reg_pkg::reg_word_u   rd_data,
    output uart_line_pkg::line_cfg_t  cfg,
    output logic                      push,
    output logic [`UART_DATA_W-1:0]   push_data,
    input  logic [`UART_FIFO_AW:0]    level,
    input  logic                      empty,
    input  logic                      full,
    input  logic                      busy
);

    import uart_line_pkg::*;
    import uart_reg_pkg::*;

    logic      ctrl_wr;
    logic      data_wr;
    logic      status_rd;
    logic      overflow;
    reg_word_u status_word;

    // ----------------------------------------------------------
    // Address decode
    // ----------------------------------------------------------

    assign ctrl_wr   = wr_en && (addr == `UART_ADDR_CTRL);
    assign data_wr   = wr_en && (addr == `UART_ADDR_DATA);
    assign status_rd = rd_en && (addr == `UART_ADDR_STATUS);

    // Byte goes straight to the FIFO on the write edge
    // A full FIFO drops it
    assign push      = data_wr && !full;
    assign push_data = wdata.data.value;

    // ----------------------------------------------------------
    // Line settings and sticky overflow
    // ----------------------------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            // Reset divisor, no parity, one stop bit
            cfg.divisor  <= `UART_RESET_DIV;
            cfg.stop_two <= 1'b0;
            cfg.parity   <= PAR_NONE;
        end
        else if (ctrl_wr)
        begin
            cfg.divisor  <= wdata.ctrl.divisor;
            cfg.stop_two <= wdata.ctrl.stop_two;
            cfg.parity   <= wdata.ctrl.parity;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            overflow <= 1'b0;
        else if (data_wr && full)
            overflow <= 1'b1;       // a dropped byte wins over a clearing read
        else if (status_rd)
            overflow <= 1'b0;
    end

    // ----------------------------------------------------------
    // Read path
    // ----------------------------------------------------------

    always_comb
    begin
        status_word                 = '0;
        status_word.status.level    = level;
        status_word.status.empty    = empty;
        status_word.status.full     = full;
        status_word.status.busy     = busy;
        status_word.status.overflow = overflow;
    end

    // Combinational from addr, unmapped addresses read as zero
    always_comb
    begin
        rd_data = '0;
        case (addr)
            `UART_ADDR_CTRL:
            begin
                rd_data.ctrl.divisor  = cfg.divisor;
                rd_data.ctrl.stop_two = cfg.stop_two;
                rd_data.ctrl.parity   = cfg.parity;
            end
            `UART_ADDR_STATUS:
                rd_data = status_word;
            default:
                rd_data = '0;
        endcase
    end

endmodule

/* hdl/uart_tx_fifo.sv */
// Transmit byte FIFO: circular buffer with occupancy count
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_tx_fifo
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    push,
    input  logic [`UART_DATA_W-1:0] push_data,
    input  logic                    pop,
    output logic                    valid,
    output logic [`UART_DATA_W-1:0] data,
    output logic [`UART_FIFO_AW:0]  level,
    output logic                    empty,
    output logic                    full
);

    logic [`UART_DATA_W-1:0]  mem [0:`UART_FIFO_DEPTH-1];
    logic [`UART_FIFO_AW-1:0] wr_ptr;
    logic [`UART_FIFO_AW-1:0] rd_ptr;
    logic [`UART_FIFO_AW:0]   count;
    logic                     do_push;
    logic                     do_pop;

    // Guard both sides so a stray request cannot corrupt the pointers
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // ----------------------------------------------------------
    // Storage
    // ----------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    // Head of queue, valid whenever something is stored
    assign data = mem[rd_ptr];

    // ----------------------------------------------------------
    // Pointers and count
    // ----------------------------------------------------------

    // Pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;

            // Simultaneous push and pop leaves the count alone
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    assign level = count;
    assign empty = (count == '0);
    assign full  = (count == `UART_FIFO_DEPTH);
    assign valid = !empty;

endmodule

/* hdl/uart_transmitter.sv */
// UART frame serializer: baud counter, start/data/parity/stop FSM, valid/ready input
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_transmitter
(
    input  logic                      clk,
    input  logic                      rst,
    input  uart_line_pkg::line_cfg_t  cfg,
    input  logic [`UART_DATA_W-1:0]   data,
    input  logic                      valid,
    output logic                      ready,
    output logic                      busy,
    output logic                      tx
);

    import uart_line_pkg::*;

    localparam int BIT_W = $clog2(`UART_DATA_W);

    // FSM encoding
    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_START  = 3'd1;
    localparam logic [2:0] S_XMIT   = 3'd2;
    localparam logic [2:0] S_PARITY = 3'd3;
    localparam logic [2:0] S_STOP   = 3'd4;

    logic [2:0]              state;
    logic [`UART_DIV_W-1:0]  baud_cnt;
    logic                    baud_stb;
    logic [BIT_W-1:0]        bit_num;
    logic [`UART_DATA_W-1:0] shift_reg;
    logic                    parity;
    line_cfg_t               cfg_q;
    logic                    last_stop;
    logic                    take;

    // ----------------------------------------------------------
    // Handshake and baud timing
    // ----------------------------------------------------------

    // Bit ends when the counter reaches the divisor latched for this frame
    assign baud_stb  = (baud_cnt == cfg_q.divisor);
    assign last_stop = (bit_num == BIT_W'(cfg_q.stop_two));

    // Ready in idle, plus one pulse at the end of the final stop bit
    assign ready = (state == S_IDLE) || ((state == S_STOP) && last_stop && baud_stb);
    assign take  = valid && ready;
    assign busy  = (state != S_IDLE);

    // Counter restarts with every frame
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            baud_cnt <= '0;
        else if (take || (state == S_IDLE) || baud_stb)
            baud_cnt <= '0;
        else
            baud_cnt <= baud_cnt + 1'b1;
    end

    // ----------------------------------------------------------
    // Frame capture
    // ----------------------------------------------------------

    // Byte shifts out LSB first
    always_ff @(posedge clk)
    begin
        if (take)
            shift_reg <= data;
        else if ((state == S_XMIT) && baud_stb)
            shift_reg <= shift_reg >> 1;
    end

    // Settings held steady for the whole frame
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cfg_q.divisor  <= `UART_RESET_DIV;
            cfg_q.stop_two <= 1'b0;
            cfg_q.parity   <= PAR_NONE;
        end
        else if (take)
            cfg_q <= cfg;
    end

    // ----------------------------------------------------------
    // State machine
    // ----------------------------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state   <= S_IDLE;
            bit_num <= '0;
            parity  <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                    if (take)
                        state <= S_START;
                S_START:
                    if (baud_stb)
                    begin
                        state   <= S_XMIT;
                        bit_num <= '0;
                    end
                S_XMIT:
                    if (baud_stb)
                    begin
                        // Running XOR of the bits already sent
                        parity  <= parity ^ shift_reg[0];
                        bit_num <= bit_num + 1'b1;
                        if (bit_num == BIT_W'(`UART_DATA_W - 1))
                        begin
                            bit_num <= '0;
                            if (cfg_q.parity != PAR_NONE)
                                state <= S_PARITY;
                            else
                                state <= S_STOP;
                        end
                    end
                S_PARITY:
                    if (baud_stb)
                        state <= S_STOP;
                S_STOP:
                    if (baud_stb)
                    begin
                        bit_num <= bit_num + 1'b1;
                        if (last_stop)
                        begin
                            bit_num <= '0;
                            // Next byte waiting, start bit follows with no gap
                            if (take)
                                state <= S_START;
                            else
                                state <= S_IDLE;
                        end
                    end
                default:
                    state <= S_IDLE;
            endcase

            // Fresh parity for every accepted byte
            if (take)
                parity <= 1'b0;
        end
    end

    // ----------------------------------------------------------
    // Line output
    // ----------------------------------------------------------

    always_comb
    begin
        case (state)
            S_IDLE:   tx = 1'b1;
            S_START:  tx = 1'b0;
            S_XMIT:   tx = shift_reg[0];
            S_PARITY: tx = (cfg_q.parity == PAR_ODD) ? ~parity : parity;
            S_STOP:   tx = 1'b1;
            default:  tx = 1'b1;
        endcase
    end

endmodule

/* hdl/uart_tx_top.sv */
// UART transmit subsystem top: register block, byte FIFO and serializer
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_tx_top
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wr_en,
    input  logic                     rd_en,
    input  logic [`UART_ADDR_W-1:0]  addr,
    input  uart_reg_pkg::reg_word_u  wdata,
    output uart_reg_pkg::reg_word_u  rd_data,
    output logic                     tx
);

    import uart_line_pkg::*;

    line_cfg_t               cfg;
    logic                    push;
    logic [`UART_DATA_W-1:0] push_data;
    logic [`UART_FIFO_AW:0]  level;
    logic                    empty;
    logic                    full;
    logic                    busy;
    logic                    fifo_valid;
    logic [`UART_DATA_W-1:0] fifo_data;
    logic                    tx_ready;
    logic                    pop;

    // ----------------------------------------------------------
    // Host registers
    // ----------------------------------------------------------

    uart_regs i_regs
    (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (wr_en),
        .rd_en     (rd_en),
        .addr      (addr),
        .wdata     (wdata),
        .rd_data   (rd_data),
        .cfg       (cfg),
        .push      (push),
        .push_data (push_data),
        .level     (level),
        .empty     (empty),
        .full      (full),
        .busy      (busy)
    );

    // Byte leaves the FIFO on the transmitter handshake
    assign pop = fifo_valid && tx_ready;

    // ----------------------------------------------------------
    // Byte buffer
    // ----------------------------------------------------------

    uart_tx_fifo i_fifo
    (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .valid     (fifo_valid),
        .data      (fifo_data),
        .level     (level),
        .empty     (empty),
        .full      (full)
    );

    // ----------------------------------------------------------
    // Serializer
    // ----------------------------------------------------------

    uart_transmitter i_tx
    (
        .clk   (clk),
        .rst   (rst),
        .cfg   (cfg),
        .data  (fifo_data),
        .valid (fifo_valid),
        .ready (tx_ready),
        .busy  (busy),
        .tx    (tx)
    );

endmodule

/* test/tb_clk_gen.sv */
// Testbench clock and reset generator
`timescale 1ns/1ps

module tb_clk_gen
(
    output logic clk,
    output logic rst
);

    // 100 ns clock period
    localparam int HALF_PERIOD = 50;

    initial
    begin
        clk = 1'b0;
        forever
            #HALF_PERIOD clk = ~clk;
    end

    // Reset held for the first three rising edges
    initial
    begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* test/tb_uart_tx.sv */
// UART transmit testbench with register access, line decoder, reference frames and compare tasks
`timescale 1ns/1ps
`include "uart_params.svh"

module tb_uart_tx;

    import uart_line_pkg::*;
    import uart_reg_pkg::*;

    // Longest frame is start, 8 data, parity and two stop bits
    localparam int FRAME_MAX  = 12;
    localparam int WAIT_LIMIT = 4000;
    localparam int IDLE_LIMIT = 200;
    // One byte in the serializer plus a full FIFO
    localparam int ACCEPT_MAX = `UART_FIFO_DEPTH + 1;

    logic                    clk;
    logic                    rst;
    logic                    wr_en;
    logic                    rd_en;
    logic [`UART_ADDR_W-1:0] addr;
    reg_word_u               wdata;
    reg_word_u               rd_data;
    logic                    tx;

    // Settings last written to CTRL and followed by the decoder
    line_cfg_t               prog_cfg;
    int                      cyc = 0;
    int                      mismatches = 0;
    int                      timeouts = 0;
    int                      line_errors = 0;

    // Expected and observed frames matched in order
    logic [FRAME_MAX-1:0]    exp_frames [$];
    int                      exp_lens [$];
    string                   exp_names [$];
    logic [FRAME_MAX-1:0]    obs_frames [$];
    int                      obs_lens [$];
    int                      start_q [$];

    tb_clk_gen i_clk_gen
    (
        .clk (clk),
        .rst (rst)
    );

    uart_tx_top i_dut
    (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .rd_en   (rd_en),
        .addr    (addr),
        .wdata   (wdata),
        .rd_data (rd_data),
        .tx      (tx)
    );

    always @(posedge clk)
        cyc <= cyc + 1;

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------

    function automatic line_cfg_t make_cfg(input int div, input parity_mode_e par,
                                           input logic two);
        line_cfg_t c;
        c.divisor  = div[`UART_DIV_W-1:0];
        c.stop_two = two;
        c.parity   = par;
        return c;
    endfunction

    function automatic int frame_len(input line_cfg_t c);
        return 10 + ((c.parity != PAR_NONE) ? 1 : 0) + (c.stop_two ? 1 : 0);
    endfunction

    // Bit k of the result is the k-th bit on the line
    function automatic logic [FRAME_MAX-1:0] expected_frame(input logic [7:0] b,
                                                          input line_cfg_t c);
        logic [FRAME_MAX-1:0] bits;
        int                   idx;
        bits = '0;
        for (int i = 0; i < 8; i++)
            bits[1 + i] = b[i];
        idx = 9;
        if (c.parity != PAR_NONE)
        begin
            bits[idx] = (c.parity == PAR_ODD) ? ~^b : ^b;
            idx++;
        end
        bits[idx] = 1'b1;
        if (c.stop_two)
            bits[idx + 1] = 1'b1;
        return bits;
    endfunction

    function automatic reg_word_u ctrl_word(input line_cfg_t c);
        reg_word_u w;
        w               = '0;
        w.ctrl.divisor  = c.divisor;
        w.ctrl.stop_two = c.stop_two;
        w.ctrl.parity   = c.parity;
        return w;
    endfunction

    function automatic reg_word_u make_status(input int level, input logic empty,
                                              input logic full, input logic busy,
                                              input logic ovf);
        reg_word_u w;
        w                 = '0;
        w.status.level    = level[`UART_FIFO_AW:0];
        w.status.empty    = empty;
        w.status.full     = full;
        w.status.busy     = busy;
        w.status.overflow = ovf;
        return w;
    endfunction

    // ----------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------

    task automatic check_frame(input string name, input logic [FRAME_MAX-1:0] expected,
                               input int exp_len, input logic [FRAME_MAX-1:0] actual,
                               input int act_len);
        if (expected !== actual || exp_len != act_len)
        begin
            mismatches++;
            $display("Fail %s: expected %03h (%0d bits), actual %03h (%0d bits)",
                     name, expected, exp_len, actual, act_len);
        end
    endtask

    task automatic check_reg(input string name, input reg_word_u expected,
                             input reg_word_u actual);
        if (expected !== actual)
        begin
            mismatches++;
            $display("Fail %s: expected %04h, actual %04h", name, expected, actual);
        end
    endtask

    task automatic check_gap(input string name, input int expected, input int actual);
        if (expected != actual)
        begin
            mismatches++;
            $display("Fail %s: expected %0d cycles, actual %0d cycles", name, expected, actual);
        end
    endtask

    // Frames are compared as soon as both sides have one
    always @(posedge clk)
    begin : compare_frames
        if (exp_frames.size() > 0 && obs_frames.size() > 0)
            check_frame(exp_names.pop_front(), exp_frames.pop_front(), exp_lens.pop_front(),
                        obs_frames.pop_front(), obs_lens.pop_front());
    end

    // ----------------------------------------------------------
    // Line decoder
    // ----------------------------------------------------------

    // Start found on the first falling clock edge with tx low before the mid-bit samples
    initial
    begin : line_decoder
        line_cfg_t            fcfg;
        logic [FRAME_MAX-1:0] bits;
        logic                 tx_prev;
        int                   len;
        int                   dv;
        tx_prev = 1'b1;
        forever
        begin
            @(negedge clk);
            if (!rst && tx_prev && !tx)
            begin
                fcfg = prog_cfg;
                dv   = int'(fcfg.divisor);
                len  = frame_len(fcfg);
                bits = '0;
                start_q.push_back(cyc);
                repeat (dv / 2) @(negedge clk);
                bits[0] = tx;
                for (int k = 1; k < len; k++)
                begin
                    repeat (dv + 1) @(negedge clk);
                    bits[k] = tx;
                end
                obs_frames.push_back(bits);
                obs_lens.push_back(len);
            end
            tx_prev = tx;
        end
    end

    // ----------------------------------------------------------
    // Host access
    // ----------------------------------------------------------

    task automatic write_reg(input logic [`UART_ADDR_W-1:0] a, input reg_word_u w);
        @(posedge clk);
        wr_en <= 1'b1;
        addr  <= a;
        wdata <= w;
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    // Sampled mid-cycle before the clearing edge
    task automatic read_reg(input logic [`UART_ADDR_W-1:0] a, output reg_word_u w);
        @(posedge clk);
        rd_en <= 1'b1;
        addr  <= a;
        @(negedge clk);
        w = rd_data;
        @(posedge clk);
        rd_en <= 1'b0;
    endtask

    task automatic write_ctrl(input line_cfg_t c);
        write_reg(`UART_ADDR_CTRL, ctrl_word(c));
        prog_cfg = c;
    endtask

    // Expected frame queued only for a byte the depth rule accepts
    task automatic send_byte(input logic [7:0] b, input bit accepted, input string name);
        reg_word_u w;
        w            = '0;
        w.data.value = b;
        write_reg(`UART_ADDR_DATA, w);
        if (accepted)
        begin
            exp_frames.push_back(expected_frame(b, prog_cfg));
            exp_lens.push_back(frame_len(prog_cfg));
            exp_names.push_back(name);
        end
    endtask

    // ----------------------------------------------------------
    // Waits
    // ----------------------------------------------------------

    task automatic wait_reset();
        int n;
        n = 0;
        while (rst && n < 20)
        begin
            @(posedge clk);
            n++;
        end
        if (rst)
        begin
            timeouts++;
            $display("Error: reset was never released");
        end
    endtask

    // Waits for all queued frames and then for the serializer to go idle
    task automatic drain_line(input string what);
        reg_word_u w;
        int        n;
        n = 0;
        while (exp_frames.size() != 0 && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (exp_frames.size() != 0)
        begin
            timeouts++;
            $display("Error: %s, %0d expected frames never appeared on tx",
                     what, exp_frames.size());
        end
        n = 0;
        read_reg(`UART_ADDR_STATUS, w);
        while (w.status.busy && n < IDLE_LIMIT)
        begin
            read_reg(`UART_ADDR_STATUS, w);
            n++;
        end
        if (w.status.busy)
        begin
            timeouts++;
            $display("Error: %s, transmitter never returned to idle", what);
        end
    endtask

    task automatic run_cfg(input int div, input parity_mode_e par, input logic two,
                           input string name);
        reg_word_u w;
        write_ctrl(make_cfg(div, par, two));
        read_reg(`UART_ADDR_CTRL, w);
        check_reg({name, " ctrl readback"}, ctrl_word(prog_cfg), w);
        for (int i = 0; i < 3; i++)
        begin
            send_byte(8'($urandom()), 1'b1, $sformatf("%s byte %0d", name, i));
            drain_line(name);
        end
    endtask

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------

    initial
    begin : main_flow
        reg_word_u w;
        int        base;
        int        n;
        wr_en    = 1'b0;
        rd_en    = 1'b0;
        addr     = '0;
        wdata    = '0;
        prog_cfg = make_cfg(`UART_RESET_DIV, PAR_NONE, 1'b0);
        void'($urandom(32'h620a));
        wait_reset();

        // Idle line and clean status after reset
        for (int i = 0; i < 20; i++)
        begin
            @(negedge clk);
            if (tx !== 1'b1)
            begin
                line_errors++;
                $display("Error: tx left the idle level right after reset");
            end
        end
        read_reg(`UART_ADDR_STATUS, w);
        check_reg("reset status", make_status(0, 1'b1, 1'b0, 1'b0, 1'b0), w);
        read_reg(`UART_ADDR_CTRL, w);
        check_reg("reset ctrl", ctrl_word(prog_cfg), w);

        // Single bytes under each line setting
        run_cfg(3, PAR_NONE, 1'b0, "plain");
        run_cfg(4, PAR_EVEN, 1'b0, "even parity");
        run_cfg(5, PAR_ODD, 1'b0, "odd parity");
        run_cfg(3, PAR_EVEN, 1'b1, "even two stop");
        run_cfg(6, PAR_ODD, 1'b1, "odd two stop");

        // Burst of five bytes sent as abutting frames
        write_ctrl(make_cfg(3, PAR_NONE, 1'b0));
        start_q.delete();
        for (int i = 0; i < 5; i++)
            send_byte(8'($urandom()), 1'b1, $sformatf("burst byte %0d", i));
        read_reg(`UART_ADDR_STATUS, w);
        check_reg("burst status", make_status(4, 1'b0, 1'b0, 1'b1, 1'b0), w);
        drain_line("burst");
        for (int i = 1; i < 5; i++)
            check_gap($sformatf("burst gap %0d", i),
                      frame_len(prog_cfg) * (int'(prog_cfg.divisor) + 1),
                      start_q[i] - start_q[i - 1]);

        // Overrun where only the serializer byte and a full FIFO survive
        write_ctrl(make_cfg(5, PAR_NONE, 1'b0));
        for (int i = 0; i < 12; i++)
            send_byte(8'($urandom()), i < ACCEPT_MAX, $sformatf("overrun byte %0d", i));
        read_reg(`UART_ADDR_STATUS, w);
        check_reg("overrun status", make_status(`UART_FIFO_DEPTH, 1'b0, 1'b1, 1'b1, 1'b1), w);
        read_reg(`UART_ADDR_STATUS, w);
        check_reg("overflow cleared", make_status(`UART_FIFO_DEPTH, 1'b0, 1'b1, 1'b1, 1'b0), w);
        drain_line("overrun");

        // Settings change during a frame applies to the next one
        write_ctrl(make_cfg(4, PAR_NONE, 1'b0));
        base = start_q.size();
        send_byte(8'($urandom()), 1'b1, "before ctrl change");
        n = 0;
        while (start_q.size() == base && n < WAIT_LIMIT)
        begin
            @(posedge clk);
            n++;
        end
        if (start_q.size() == base)
        begin
            timeouts++;
            $display("Error: frame before the settings change never started");
        end
        write_ctrl(make_cfg(2, PAR_ODD, 1'b1));
        send_byte(8'($urandom()), 1'b1, "after ctrl change");
        drain_line("ctrl change");

        if (obs_frames.size() != 0)
        begin
            line_errors++;
            $display("Error: %0d frames on tx that no byte accounts for", obs_frames.size());
        end

        $display("Errors: %0d mismatches, %0d timeouts, %0d line errors",
                 mismatches, timeouts, line_errors);
        if (mismatches == 0 && timeouts == 0 && line_errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

/* tb.f */
+incdir+hdl
hdl/uart_line_pkg.sv
hdl/uart_reg_pkg.sv
hdl/uart_regs.sv
hdl/uart_tx_fifo.sv
hdl/uart_transmitter.sv
hdl/uart_tx_top.sv
test/tb_clk_gen.sv
test/tb_uart_tx.sv

/* run_sim.sh */
#!/bin/sh
# Build the UART transmit testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timescale 1ns/1ps -f tb.f --top-module tb_uart_tx -o tb_uart_tx \
    && ./obj_dir/tb_uart_tx > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "No pass line in sim.log"; exit 1; }
exit 0
